// File: mam_config.svh
////////////////////////////////////////////////////////////////////////////
// Debug memory access unit configuration
// Sets the word, address and beat-count widths and the depth of the
// on-chip RAM target
////////////////////////////////////////////////////////////////////////////

`ifndef MAM_CONFIG_SVH
`define MAM_CONFIG_SVH

// Debug link and bus data word, in bits
`define MAM_XLEN 16

// System bus address width
`define MAM_PLEN 32

`define MAM_BEATW 13     // Beat count field of the header word

// RAM depth in words, indexed by the address bits above the byte offset
`define MAM_MEM_WORDS 256

`endif

// File: mam_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Debug memory access unit types
// Opcodes, bus cycle types and the FSM state encodings
////////////////////////////////////////////////////////////////////////////

package mam_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mam_op_e;

  // Cycle type on the system bus
  typedef enum logic [2:0] {
    BURST_INCR = 3'b010,  // Incrementing burst, more beats follow
    BURST_END  = 3'b111   // Single access or final beat
  } mam_burst_e;

  typedef enum logic [2:0] {
    IDLE, WRITE_LAST, WRITE_LAST_WAIT, WRITE, WRITE_WAIT, READ, READ_WAIT
  } mam_state_e;

  typedef enum logic [2:0] {
    HDR, ADDR_HI, ADDR_LO, ISSUE, WDATA
  } mam_parse_state_e;

endpackage

// File: mam_if.sv
////////////////////////////////////////////////////////////////////////////
// Debug memory access unit interfaces
// Request channel from the command parser to the bus master, and the
// pipelined system bus from the bus master to the RAM target
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mam_config.svh"

interface mam_req_if import mam_pkg::*; ();
  logic                  req_valid;    // Request channel
  logic                  req_ready;
  mam_op_e               req_op;
  logic [`MAM_PLEN-1:0]  req_addr;
  logic                  req_burst;    // Incremental burst when set
  logic [`MAM_BEATW-1:0] req_beats;
  logic                  write_valid;  // Write data channel
  logic                  write_ready;
  logic [`MAM_XLEN-1:0]  write_data;
  logic                  read_valid;   // Read data channel
  logic                  read_ready;
  logic [`MAM_XLEN-1:0]  read_data;

  modport parser (
    output req_valid, req_op, req_addr, req_burst, req_beats,
    output write_valid, write_data,
    input  req_ready, write_ready
  );

  modport master (
    input  req_valid, req_op, req_addr, req_burst, req_beats,
    input  write_valid, write_data, read_ready,
    output req_ready, write_ready, read_valid, read_data
  );
endinterface

interface mam_bus_if import mam_pkg::*; ();
  logic                 sel;    // Beat in progress
  logic [`MAM_PLEN-1:0] addr;
  logic [`MAM_XLEN-1:0] wdata;
  logic                 write;
  mam_burst_e           burst;
  logic [`MAM_XLEN-1:0] rdata;
  logic                 ready;  // Beat completes with sel

  modport master (output sel, addr, wdata, write, burst, input rdata, ready);
  modport target (input sel, addr, wdata, write, burst, output rdata, ready);
endinterface

// File: mam_cmd_parser.sv
////////////////////////////////////////////////////////////////////////////
// Debug command parser
// Collects the header and the two address halves from the debug word
// stream, presents one memory request, then forwards the write-data words
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mam_config.svh"

module mam_cmd_parser
  import mam_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  input  logic [`MAM_XLEN-1:0] in_data_i,
  output logic                 in_ready_o,
  mam_req_if.parser            req
);

  mam_parse_state_e      state;
  mam_op_e               op_q;
  logic                  burst_q;
  logic [`MAM_BEATW-1:0] beats_q;
  logic [`MAM_PLEN-1:0]  addr_q;
  logic [`MAM_BEATW-1:0] wcnt_q;   // Write words still to forward
  logic [`MAM_BEATW-1:0] hdr_beats;
  logic                  hdr_burst;
  logic                  in_fire;

  assign hdr_burst = in_data_i[`MAM_XLEN-2];
  // Single accesses and empty bursts both become one beat
  assign hdr_beats = (!hdr_burst || in_data_i[`MAM_BEATW-1:0] == '0) ?
                     `MAM_BEATW'd1 : in_data_i[`MAM_BEATW-1:0];

  always_comb begin
    case (state)
      ISSUE:   in_ready_o = 1'b0;             // Stall while the request waits
      WDATA:   in_ready_o = req.write_ready;  // Pass master back-pressure through
      default: in_ready_o = 1'b1;
    endcase
  end

  assign in_fire = in_valid_i & in_ready_o;

  // Request channel
  assign req.req_valid = (state == ISSUE);
  assign req.req_op    = op_q;
  assign req.req_addr  = addr_q;
  assign req.req_burst = burst_q;
  assign req.req_beats = beats_q;

  // Write words go straight from the link to the master
  assign req.write_valid = (state == WDATA) & in_valid_i;
  assign req.write_data  = in_data_i;

  ////////////////////////////////////////////////////////////////////////////
  // Parse FSM

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state  <= HDR;
      wcnt_q <= '0;
    end else begin
      case (state)
        HDR:     if (in_fire) state <= ADDR_HI;
        ADDR_HI: if (in_fire) state <= ADDR_LO;
        ADDR_LO: if (in_fire) state <= ISSUE;
        ISSUE: begin
          if (req.req_ready) begin
            if (op_q == OP_WRITE) begin
              state  <= WDATA;
              wcnt_q <= beats_q;
            end else begin
              state <= HDR;  // Read data returns through the master
            end
          end
        end
        WDATA: begin
          if (in_fire) begin
            wcnt_q <= wcnt_q - 1'b1;
            if (wcnt_q == `MAM_BEATW'd1) state <= HDR;  // Last write word
          end
        end
        default: state <= HDR;
      endcase
    end
  end

  // Header and address fields
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      case (state)
        HDR: begin
          op_q    <= mam_op_e'(in_data_i[`MAM_XLEN-1]);
          burst_q <= hdr_burst;
          beats_q <= hdr_beats;
        end
        ADDR_HI: addr_q[`MAM_PLEN-1:`MAM_XLEN] <= in_data_i;
        ADDR_LO: addr_q[`MAM_XLEN-1:0]         <= in_data_i;
        default: ;
      endcase
    end
  end

endmodule

// File: mam_bus_master.sv
////////////////////////////////////////////////////////////////////////////
// Debug memory access bus master
// Turns each request into single or incrementing burst beats on the
// system bus, sequences the write data in and holds each read word
// until the host takes it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mam_config.svh"

module mam_bus_master
  import mam_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  mam_req_if.master req,
  mam_bus_if.master bus
);

  localparam int unsigned STEP = `MAM_XLEN / 8;  // Byte address increment per beat

  mam_state_e            state, nxt_state;
  logic [`MAM_BEATW-1:0] beats, nxt_beats;       // Beats not yet completed
  logic [`MAM_PLEN-1:0]  nxt_addr;
  logic [`MAM_XLEN-1:0]  nxt_wdata;
  logic [`MAM_XLEN-1:0]  nxt_rdata;
  logic                  nxt_write;
  mam_burst_e            nxt_burst;
  logic                  req_last;               // Request is a single beat

  assign req_last = !req.req_burst || (req.req_beats == `MAM_BEATW'd1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= IDLE;
      beats <= '0;
    end else begin
      state <= nxt_state;
      beats <= nxt_beats;
    end
  end

  // Bus payload and the held read word
  always_ff @(posedge clk_i) begin
    bus.addr      <= nxt_addr;
    bus.wdata     <= nxt_wdata;
    bus.write     <= nxt_write;
    bus.burst     <= nxt_burst;
    req.read_data <= nxt_rdata;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and handshakes

  always_comb begin
    nxt_state = state;
    nxt_beats = beats;
    nxt_addr  = bus.addr;
    nxt_wdata = bus.wdata;
    nxt_write = bus.write;
    nxt_burst = bus.burst;
    nxt_rdata = req.read_data;

    req.req_ready   = 1'b0;
    req.write_ready = 1'b0;
    req.read_valid  = 1'b0;
    bus.sel         = 1'b0;

    case (state)
      IDLE: begin
        req.req_ready = 1'b1;
        if (req.req_valid) begin
          nxt_addr  = req.req_addr;
          nxt_beats = req.req_beats;
          nxt_burst = req_last ? BURST_END : BURST_INCR;
          if (req.req_op == OP_WRITE) begin
            nxt_write = 1'b1;
            nxt_state = req_last ? WRITE_LAST_WAIT : WRITE_WAIT;  // Data follows the request
          end else begin
            nxt_write = 1'b0;
            nxt_state = READ;
          end
        end
      end

      WRITE_WAIT: begin
        req.write_ready = 1'b1;
        if (req.write_valid) begin
          nxt_wdata = req.write_data;
          nxt_state = WRITE;
        end
      end

      WRITE: begin
        bus.sel = 1'b1;
        if (bus.ready) begin
          req.write_ready = 1'b1;  // Fetch the next word in the completing cycle
          nxt_addr        = bus.addr + STEP;
          nxt_beats       = beats - 1'b1;
          if (req.write_valid) nxt_wdata = req.write_data;
          if (beats == `MAM_BEATW'd2) begin
            nxt_burst = BURST_END;  // Next beat closes the burst
            nxt_state = req.write_valid ? WRITE_LAST : WRITE_LAST_WAIT;
          end else begin
            nxt_state = req.write_valid ? WRITE : WRITE_WAIT;
          end
        end
      end

      WRITE_LAST_WAIT: begin
        req.write_ready = 1'b1;
        if (req.write_valid) begin
          nxt_wdata = req.write_data;
          nxt_state = WRITE_LAST;
        end
      end

      WRITE_LAST: begin
        bus.sel = 1'b1;
        if (bus.ready) begin
          nxt_addr  = bus.addr + STEP;
          nxt_beats = beats - 1'b1;
          nxt_state = IDLE;
        end
      end

      READ: begin
        bus.sel = 1'b1;
        if (bus.ready) begin
          nxt_rdata = bus.rdata;  // Captured in the ready cycle
          nxt_addr  = bus.addr + STEP;
          nxt_beats = beats - 1'b1;
          nxt_state = READ_WAIT;
        end
      end

      // No new beat until the host takes the held word
      READ_WAIT: begin
        req.read_valid = 1'b1;
        if (req.read_ready) begin
          if (beats == `MAM_BEATW'd1) nxt_burst = BURST_END;
          nxt_state = (beats == '0) ? IDLE : READ;
        end
      end

      default: nxt_state = IDLE;
    endcase
  end

endmodule

// File: mam_mem.sv
////////////////////////////////////////////////////////////////////////////
// On-chip RAM bus target
// Word RAM that inserts one wait state into every beat
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mam_config.svh"

module mam_mem (
  input  logic      clk_i,
  input  logic      rst_i,
  mam_bus_if.target bus
);

  localparam int unsigned AW = $clog2(`MAM_MEM_WORDS);

  logic [`MAM_XLEN-1:0] mem [`MAM_MEM_WORDS];
  logic [AW-1:0]        idx;
  logic                 wait_q;  // Set in the second cycle of a beat

  assign idx = bus.addr[AW:1];  // Word index above the byte offset

  // Wait-state toggle, restarts whenever sel drops
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= bus.sel & ~wait_q;
    end
  end

  assign bus.ready = bus.sel & wait_q;

  always_ff @(posedge clk_i) begin
    if (bus.sel && !wait_q) begin
      bus.rdata <= mem[idx];  // Read in the wait cycle, valid at ready
    end
    if (bus.ready && bus.write) begin
      mem[idx] <= bus.wdata;  // Store on the completing cycle
    end
  end

endmodule

// File: mam_top.sv
////////////////////////////////////////////////////////////////////////////
// Debug memory access unit top level
// Command parser, bus master and RAM target behind plain stream ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mam_config.svh"

module mam_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,   // Debug command words
  input  logic [`MAM_XLEN-1:0] in_data_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,  // Read data words
  output logic [`MAM_XLEN-1:0] out_data_o,
  input  logic                 out_ready_i
);

  mam_req_if u_req_if ();
  mam_bus_if u_bus_if ();

  // Read channel goes straight to the host port
  assign u_req_if.read_ready = out_ready_i;
  assign out_valid_o         = u_req_if.read_valid;
  assign out_data_o          = u_req_if.read_data;

  mam_cmd_parser u_parser (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_valid_i (in_valid_i),
    .in_data_i  (in_data_i),
    .in_ready_o (in_ready_o),
    .req        (u_req_if)
  );

  mam_bus_master u_master (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req   (u_req_if),
    .bus   (u_bus_if)
  );

  mam_mem u_mem (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (u_bus_if)
  );

endmodule

// File: tb_mam.sv
////////////////////////////////////////////////////////////////////////////
// Debug memory access unit testbench
// Plays debug words from the stimulus file into the DUT, checks each
// returned read word and stalls the read port at random
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mam_config.svh"

module tb_mam;

  logic                 clk_i;
  logic                 rst_i;
  logic                 in_valid_i;
  logic [`MAM_XLEN-1:0] in_data_i;
  logic                 in_ready_o;
  logic                 out_valid_o;
  logic [`MAM_XLEN-1:0] out_data_o;
  logic                 out_ready_i;

  byte                  kind_q [$];  // Line kind, w or r
  logic [`MAM_XLEN-1:0] word_q [$];  // Word to drive or to expect
  logic [`MAM_XLEN-1:0] rd_q   [$];  // Read words taken from the DUT
  bit                   loaded;
  int unsigned          seed;

  mam_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input string name, input logic [`MAM_XLEN-1:0] got,
                          input logic [`MAM_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run("value check failed");
    end
  endtask

  // Lines starting with # are comments
  task automatic load_stimulus();
    int                   fd;
    int                   n;
    string                line;
    logic [`MAM_XLEN-1:0] val;
    fd = $fopen("mam_input.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open stimulus file mam_input.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() >= 2 && line[0] != "#") begin
          n = $sscanf(line.substr(1, line.len() - 1), " %h", val);
          if (n != 1 || (line[0] != "w" && line[0] != "r")) begin
            abort_run({"bad stimulus line: ", line});
          end else begin
            kind_q.push_back(line[0]);
            word_q.push_back(val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Hold the word until the DUT takes it, return 1 ns after that edge
  task automatic send_word(input logic [`MAM_XLEN-1:0] data);
    bit taken;
    in_valid_i = 1'b1;
    in_data_i  = data;
    do begin
      @(negedge clk_i);
      taken = in_ready_o;  // Stable half a cycle before the edge
      @(posedge clk_i);
      #1;
    end while (!taken);
  endtask

  task automatic expect_word(input logic [`MAM_XLEN-1:0] exp);
    logic [`MAM_XLEN-1:0] got;
    in_valid_i = 1'b0;
    while (rd_q.size() == 0) begin
      @(posedge clk_i);
      #1;
    end
    got = rd_q.pop_front();
    check_eq("out_data_o", got, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Read port: random back-pressure and transfer monitor

  initial begin
    seed        = $urandom(2788);  // Fixed stall pattern
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      out_ready_i = rst_i ? 1'b0 : $urandom() % 2 == 1;  // About half the cycles
    end
  end

  // Both sides stable here, so the transfer happens at the next edge
  always @(negedge clk_i) begin
    if (!rst_i && out_valid_o && out_ready_i) rd_q.push_back(out_data_o);
  end

  // Watchdog, 40 cycles per stimulus line plus reset and drain
  initial begin
    wait (loaded);
    repeat (kind_q.size() * 40 + 100) @(posedge clk_i);
    abort_run("timeout: the DUT stopped making progress");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    in_data_i  = '0;
    load_stimulus();
    loaded = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_eq("in_ready_o", `MAM_XLEN'(in_ready_o), `MAM_XLEN'(1));    // Idle after reset
    check_eq("out_valid_o", `MAM_XLEN'(out_valid_o), `MAM_XLEN'(0));
    foreach (kind_q[i]) begin
      if (kind_q[i] == "w") send_word(word_q[i]);
      else expect_word(word_q[i]);
    end
    in_valid_i = 1'b0;
    repeat (20) @(posedge clk_i);  // Give a stray word time to show up
    if (rd_q.size() != 0) begin
      abort_run("unexpected extra read word on out_data_o");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: mam_input.txt
# Column 1: w drives a debug word into the DUT, r expects a read word
# Column 2: the word in hex
# Burst write of 4 words at 0x0040
w c004
w 0000
w 0040
w 1111
w 2222
w 3333
w 4444
# Burst read of 4 words at 0x0040
w 4004
w 0000
w 0040
r 1111
r 2222
r 3333
r 4444
# Single write with a large beat count, only one data word follows
w 8fff
w 0000
w 0042
w beef
# Burst read of 3, the neighbors of 0x0042 keep their values
w 4003
w 0000
w 0040
r 1111
r beef
r 3333
# Single read with a large beat count returns one word
w 0fff
w 0000
w 0042
r beef

// File: project.f
+incdir+.
mam_pkg.sv
mam_if.sv
mam_cmd_parser.sv
mam_bus_master.sv
mam_mem.sv
mam_top.sv
tb_mam.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_mam -o sim_tb_mam
./obj_dir/sim_tb_mam
